/* verilog.f */
+incdir+include
src/dbg_cmd_pkg.sv
src/dbg_port_pkg.sv
src/dbg_bus_module.sv
src/dbg_cpu_module.sv
src/dbg_top.sv
verif/tb_dbg_top.sv

/* Bender.yml */
package:
  name: dbg_unit

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - src/dbg_cmd_pkg.sv
      - src/dbg_port_pkg.sv
      - src/dbg_bus_module.sv
      - src/dbg_cpu_module.sv
      - src/dbg_top.sv
  - target: test
    include_dirs:
      - include
    files:
      - verif/tb_dbg_top.sv

/* verif/tb_dbg_top.sv */
`default_nettype none

`include "dbg_settings.svh"

module tb_dbg_top
  import dbg_cmd_pkg::*;
  import dbg_port_pkg::*;
();

  timeunit 1ns;
  timeprecision 1ps;

  // Row actions around the scan
  localparam int ACT_NONE    = 0;
  localparam int ACT_BP      = 1;
  localparam int ACT_HOLD    = 2;
  localparam int ACT_RELEASE = 3;

  // Cycle budget per row
  localparam int ROW_CYCLES = 2 * 75 + 10;

  typedef struct {
    string                        name;
    bit                           sel;
    dbg_module_e                  mod;
    logic [`DBG_OPCODE_LEN-1:0]   op;
    logic [`DBG_ADDR_WIDTH-1:0]   addr;
    logic [`DBG_DATA_WIDTH-1:0]   data;
    logic [`DBG_READBACK_LEN-1:0] exp_rb;
    bit                           chk;
    int                           act;
    bit                           exp_stall;
  } row_t;

  logic     tck_i = 1'b0;
  logic     tlr_i;
  logic     tdi_i;
  logic     tdo_o;
  logic     shift_dr_i;
  logic     capture_dr_i;
  logic     update_dr_i;
  logic     debug_select_i;
  bus_req_t bus_req_o;
  bus_rsp_t bus_rsp_i = '0;
  cpu_req_t cpu_req_o;
  cpu_rsp_t cpu_rsp_i = '0;
  logic     cpu_bp_i;
  logic     cpu_stall_o;

  row_t                         rows[$];
  logic [`DBG_READBACK_LEN-1:0] rb;
  int                           rb_errors;
  int                           stall_errors;
  int                           port_errors;
  int                           cycle_count;
  int                           cycle_limit;

  // Memory and CPU models
  logic [31:0] mem [0:255];
  logic [31:0] cpu_regs [0:15];
  int          seed = 87027;
  logic        hold_ack;
  logic        mem_active;
  int          mem_wait;
  int          cpu_wait;

  dbg_top i_dbg_top (
    .tck_i         (tck_i),
    .tlr_i         (tlr_i),
    .tdi_i         (tdi_i),
    .tdo_o         (tdo_o),
    .shift_dr_i    (shift_dr_i),
    .capture_dr_i  (capture_dr_i),
    .update_dr_i   (update_dr_i),
    .debug_select_i(debug_select_i),
    .bus_req_o     (bus_req_o),
    .bus_rsp_i     (bus_rsp_i),
    .cpu_req_o     (cpu_req_o),
    .cpu_rsp_i     (cpu_rsp_i),
    .cpu_bp_i      (cpu_bp_i),
    .cpu_stall_o   (cpu_stall_o)
  );

  ////////////////////////////////////////
  // Clock and run limit
  ////////////////////////////////////////

  always #5 tck_i = ~tck_i;

  always @(posedge tck_i) begin
    cycle_count++;
    if (cycle_count > cycle_limit) begin
      $display("Timeout: run did not finish within %0d cycles", cycle_limit);
      $display("Simulation finished: FAIL");
      $finish;
    end
  end

  ////////////////////////////////////////
  // Memory model
  ////////////////////////////////////////

  // Random ack latency 1..4, bit 31 errors
  always @(negedge tck_i) begin
    if (bus_rsp_i.ack) begin
      bus_rsp_i = '0;
    end else if (bus_req_o.stb) begin
      if (!mem_active) begin
        mem_active = 1'b1;
        mem_wait   = 1 + ({$random(seed)} % 4);
      end
      // Ack held off while the hold flag is up
      if (!hold_ack) begin
        mem_wait--;
        if (mem_wait == 0) begin
          mem_active      = 1'b0;
          bus_rsp_i.ack   = 1'b1;
          bus_rsp_i.err   = bus_req_o.addr[31];
          bus_rsp_i.rdata = '0;
          if (!bus_req_o.addr[31]) begin
            if (bus_req_o.we) begin
              mem[bus_req_o.addr[9:2]] = bus_req_o.wdata;
            end else begin
              bus_rsp_i.rdata = mem[bus_req_o.addr[9:2]];
            end
          end
        end
      end
    end
  end

  ////////////////////////////////////////
  // CPU model
  ////////////////////////////////////////

  // Fixed two-cycle ack
  always @(negedge tck_i) begin
    if (cpu_rsp_i.ack) begin
      cpu_rsp_i = '0;
    end else if (cpu_req_o.stb) begin
      cpu_wait++;
      if (cpu_wait == 2) begin
        cpu_wait      = 0;
        cpu_rsp_i.ack = 1'b1;
        if (cpu_req_o.we) begin
          cpu_regs[cpu_req_o.addr[3:0]] = cpu_req_o.wdata;
          cpu_rsp_i.rdata = '0;
        end else begin
          cpu_rsp_i.rdata = cpu_regs[cpu_req_o.addr[3:0]];
        end
      end
    end
  end

  ////////////////////////////////////////
  // Helpers
  ////////////////////////////////////////

  task automatic add_row(input string name, input bit sel, input dbg_module_e mod,
                         input logic [3:0] op, input logic [31:0] addr,
                         input logic [31:0] data, input logic [32:0] exp_rb,
                         input bit chk, input int act, input bit exp_stall);
    row_t r;
    r = '{name, sel, mod, op, addr, data, exp_rb, chk, act, exp_stall};
    rows.push_back(r);
  endtask

  // Select scans carry only the module number
  function automatic logic [`DBG_DATAREG_LEN-1:0] make_word(input row_t r);
    logic [`DBG_DATAREG_LEN-1:0] w;
    if (r.sel) begin
      w = {1'b1, r.mod, {(`DBG_DATAREG_LEN - 3){1'b0}}};
    end else begin
      w = {1'b0, r.op, r.addr, r.data};
    end
    return w;
  endfunction

  // Capture, 69 shifts, update; starts and ends on a falling edge
  task automatic run_scan(input logic [`DBG_DATAREG_LEN-1:0] word,
                          output logic [`DBG_READBACK_LEN-1:0] data);
    int i;
    data         = '0;
    capture_dr_i = 1'b1;
    @(negedge tck_i);
    capture_dr_i = 1'b0;
    shift_dr_i   = 1'b1;
    for (i = 0; i < `DBG_DATAREG_LEN; i++) begin
      tdi_i = word[i];
      // tdo settled since the last rising edge
      if (i < `DBG_READBACK_LEN) begin
        data[i] = tdo_o;
      end
      @(negedge tck_i);
    end
    shift_dr_i  = 1'b0;
    update_dr_i = 1'b1;
    @(negedge tck_i);
    update_dr_i = 1'b0;
  endtask

  // Port request one edge after update, built from the row fields
  task automatic check_request(input row_t r);
    bus_req_t exp_bus;
    cpu_req_t exp_cpu;
    bit       bus_launch;
    bit       cpu_launch;
    bus_launch = !r.sel && (r.mod == MOD_BUS) &&
                 ((r.op == BUS_WRITE) || (r.op == BUS_READ));
    cpu_launch = !r.sel && (r.mod == MOD_CPU) &&
                 ((r.op == CPU_REG_WRITE) || (r.op == CPU_REG_READ));
    exp_bus.stb   = 1'b1;
    exp_bus.we    = (r.op == BUS_WRITE);
    exp_bus.addr  = r.addr;
    exp_bus.wdata = r.data;
    exp_cpu.stb   = 1'b1;
    exp_cpu.we    = (r.op == CPU_REG_WRITE);
    exp_cpu.addr  = r.addr[`DBG_CPU_REG_ADDR_LEN-1:0];
    exp_cpu.wdata = r.data;
    if (bus_launch) begin
      if (bus_req_o !== exp_bus) begin
        port_errors++;
        $display("ERR %s: bus request expected %h, actual %h", r.name, exp_bus, bus_req_o);
      end
    end else if (cpu_launch) begin
      if (cpu_req_o !== exp_cpu) begin
        port_errors++;
        $display("ERR %s: cpu request expected %h, actual %h", r.name, exp_cpu, cpu_req_o);
      end
    end else if (r.act != ACT_RELEASE) begin
      // No access may start, held read only spans the release row
      if ({bus_req_o.stb, cpu_req_o.stb} !== 2'b00) begin
        port_errors++;
        $display("ERR %s: bus and cpu stb expected %b, actual %b", r.name, 2'b00,
                 {bus_req_o.stb, cpu_req_o.stb});
      end
    end
  endtask

  task automatic pulse_breakpoint();
    cpu_bp_i = 1'b1;
    @(negedge tck_i);
    cpu_bp_i = 1'b0;
    @(negedge tck_i);
  endtask

  // Both ports quiet again
  task automatic wait_idle();
    while (bus_req_o.stb || cpu_req_o.stb) begin
      @(negedge tck_i);
    end
  endtask

  ////////////////////////////////////////
  // Stimulus table
  ////////////////////////////////////////

  // Readback shows state from before the row's own update
  task automatic load_table();
    add_row("bus_wr_a", 0, MOD_BUS, BUS_WRITE, 32'h10, 32'hCAFE0001, 33'h0, 1, ACT_NONE, 0);
    add_row("bus_rd_a", 0, MOD_BUS, BUS_READ, 32'h10, 32'h0, 33'h0, 1, ACT_NONE, 0);
    add_row("bus_rb_a", 0, MOD_BUS, BUS_NOP, 32'h0, 32'h0, 33'h0CAFE0001, 1, ACT_NONE, 0);
    add_row("sel_jsp", 1, MOD_JSP, BUS_NOP, 32'h0, 32'h0, 33'h0CAFE0001, 1, ACT_NONE, 0);
    // Reserved slot reads as zero
    add_row("jsp_zero", 0, MOD_JSP, BUS_NOP, 32'h0, 32'h0, 33'h0, 1, ACT_NONE, 0);
    add_row("sel_bus", 1, MOD_BUS, BUS_NOP, 32'h0, 32'h0, 33'h0, 1, ACT_NONE, 0);
    add_row("bus_wr_b", 0, MOD_BUS, BUS_WRITE, 32'h20, 32'h12345678, 33'h0CAFE0001, 1,
            ACT_NONE, 0);
    add_row("bus_wr_c", 0, MOD_BUS, BUS_WRITE, 32'h44, 32'hA5A55A5A, 33'h0CAFE0001, 1,
            ACT_NONE, 0);
    add_row("bus_wr_d", 0, MOD_BUS, BUS_WRITE, 32'h3FC, 32'h0BADF00D, 33'h0CAFE0001, 1,
            ACT_NONE, 0);
    add_row("bus_rd_b", 0, MOD_BUS, BUS_READ, 32'h20, 32'h0, 33'h0CAFE0001, 1, ACT_NONE, 0);
    add_row("bus_rd_c", 0, MOD_BUS, BUS_READ, 32'h44, 32'h0, 33'h012345678, 1, ACT_NONE, 0);
    add_row("bus_rd_d", 0, MOD_BUS, BUS_READ, 32'h3FC, 32'h0, 33'h0A5A55A5A, 1, ACT_NONE, 0);
    add_row("bus_rd_a2", 0, MOD_BUS, BUS_READ, 32'h10, 32'h0, 33'h00BADF00D, 1, ACT_NONE, 0);
    // Bit 31 set gives err, read word comes back zero
    add_row("bus_rd_err", 0, MOD_BUS, BUS_READ, 32'h80000010, 32'h0, 33'h0CAFE0001, 1,
            ACT_NONE, 0);
    add_row("bus_rb_err", 0, MOD_BUS, BUS_NOP, 32'h0, 32'h0, 33'h100000000, 1, ACT_NONE, 0);
    add_row("bus_rd_ok", 0, MOD_BUS, BUS_READ, 32'h20, 32'h0, 33'h100000000, 1, ACT_NONE, 0);
    add_row("sel_cpu", 1, MOD_CPU, BUS_NOP, 32'h0, 32'h0, 33'h012345678, 1, ACT_NONE, 0);
    add_row("cpu_wr", 0, MOD_CPU, CPU_REG_WRITE, 32'h5, 32'h5EED1234, 33'h0, 1, ACT_NONE, 0);
    add_row("cpu_rd", 0, MOD_CPU, CPU_REG_READ, 32'h5, 32'h0, 33'h0, 1, ACT_NONE, 0);
    add_row("cpu_rb", 0, MOD_CPU, CPU_NOP, 32'h0, 32'h0, 33'h05EED1234, 1, ACT_NONE, 0);
    // Stall set, cleared, then set by a breakpoint
    add_row("cpu_stall_on", 0, MOD_CPU, CPU_STALL, 32'h0, 32'h1, 33'h05EED1234, 1, ACT_NONE, 1);
    add_row("cpu_stall_rb", 0, MOD_CPU, CPU_NOP, 32'h0, 32'h0, 33'h15EED1234, 1, ACT_NONE, 1);
    add_row("cpu_stall_off", 0, MOD_CPU, CPU_STALL, 32'h0, 32'h0, 33'h15EED1234, 1,
            ACT_NONE, 0);
    add_row("cpu_unstall_rb", 0, MOD_CPU, CPU_NOP, 32'h0, 32'h0, 33'h05EED1234, 1,
            ACT_NONE, 0);
    add_row("cpu_bp", 0, MOD_CPU, CPU_NOP, 32'h0, 32'h0, 33'h15EED1234, 1, ACT_BP, 1);
    add_row("cpu_bp_clear", 0, MOD_CPU, CPU_STALL, 32'h0, 32'h0, 33'h15EED1234, 1, ACT_NONE, 0);
    // Reselect under a pending bus read is dropped
    add_row("sel_bus2", 1, MOD_BUS, BUS_NOP, 32'h0, 32'h0, 33'h05EED1234, 1, ACT_NONE, 0);
    add_row("bus_rd_hold", 0, MOD_BUS, BUS_READ, 32'h44, 32'h0, 33'h012345678, 1, ACT_HOLD, 0);
    add_row("sel_cpu_drop", 1, MOD_CPU, BUS_NOP, 32'h0, 32'h0, 33'h012345678, 1,
            ACT_RELEASE, 0);
    add_row("bus_after_drop", 0, MOD_BUS, BUS_NOP, 32'h0, 32'h0, 33'h0A5A55A5A, 1,
            ACT_NONE, 0);
  endtask

  ////////////////////////////////////////
  // Main sequence
  ////////////////////////////////////////

  initial begin
    tlr_i          = 1'b1;
    tdi_i          = 1'b0;
    shift_dr_i     = 1'b0;
    capture_dr_i   = 1'b0;
    update_dr_i    = 1'b0;
    debug_select_i = 1'b0;
    cpu_bp_i       = 1'b0;
    hold_ack       = 1'b0;
    mem_active     = 1'b0;
    mem_wait       = 0;
    cpu_wait       = 0;
    rb_errors      = 0;
    stall_errors   = 0;
    port_errors    = 0;
    cycle_count    = 0;
    load_table();
    cycle_limit = rows.size() * ROW_CYCLES;
    repeat (3) @(negedge tck_i);
    tlr_i          = 1'b0;
    debug_select_i = 1'b1;
    @(negedge tck_i);
    foreach (rows[r]) begin
      if (rows[r].act == ACT_BP) begin
        pulse_breakpoint();
      end
      if (rows[r].act == ACT_HOLD) begin
        hold_ack = 1'b1;
      end
      run_scan(make_word(rows[r]), rb);
      if (rows[r].chk && (rb !== rows[r].exp_rb)) begin
        rb_errors++;
        $display("ERR %s: readback expected %h, actual %h", rows[r].name, rows[r].exp_rb, rb);
      end
      check_request(rows[r]);
      if (rows[r].act == ACT_RELEASE) begin
        hold_ack = 1'b0;
      end
      // Held access stays open into the next row
      if (rows[r].act != ACT_HOLD) begin
        wait_idle();
      end
      if (cpu_stall_o !== rows[r].exp_stall) begin
        stall_errors++;
        $display("ERR %s: stall expected %b, actual %b", rows[r].name, rows[r].exp_stall,
                 cpu_stall_o);
      end
    end
    $display("Done: %0d rows, %0d readback errors, %0d stall errors, %0d port errors",
             rows.size(), rb_errors, stall_errors, port_errors);
    if ((rb_errors + stall_errors + port_errors) == 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* src/dbg_top.sv */
`default_nettype none

`include "dbg_settings.svh"

module dbg_top
  import dbg_cmd_pkg::*;
  import dbg_port_pkg::*;
(
  // JTAG pins
  input  logic     tck_i,
  input  logic     tlr_i,
  input  logic     tdi_i,
  output logic     tdo_o,
  // Decoded TAP strobes
  input  logic     shift_dr_i,
  input  logic     capture_dr_i,
  input  logic     update_dr_i,
  input  logic     debug_select_i,
  // Memory bus
  output bus_req_t bus_req_o,
  input  bus_rsp_t bus_rsp_i,
  // CPU side
  output cpu_req_t cpu_req_o,
  input  cpu_rsp_t cpu_rsp_i,
  input  logic     cpu_bp_i,
  output logic     cpu_stall_o
);

  localparam int unsigned NUM_MODULES = 2 ** `DBG_MODULE_ID_LEN;

  // Main chain
  logic [`DBG_DATAREG_LEN-1:0] shift_q;
  dbg_cmd_t                    cmd;
  logic                        select_cmd;

  // Module number and decode
  dbg_module_e                 module_q;
  logic [NUM_MODULES-1:0]      module_sel;
  logic [NUM_MODULES-1:0]      module_tdo;
  logic                        select_inhibit;

  // Strobes seen by the modules
  logic                        scan_capture;
  logic                        scan_shift;
  logic                        cmd_update;

  // Per-module returns
  logic                        bus_tdo;
  logic                        bus_inhibit;
  logic                        cpu_tdo;
  logic                        cpu_inhibit;

  ////////////////////////////////////////
  // Data shift register
  ////////////////////////////////////////

  // LSB first, tdi enters at the select bit
  always_ff @(posedge tck_i or posedge tlr_i) begin
    if (tlr_i) begin
      shift_q <= '0;
    end else if (debug_select_i && shift_dr_i) begin
      shift_q <= {tdi_i, shift_q[`DBG_DATAREG_LEN-1:1]};
    end
  end

  assign select_cmd = shift_q[`DBG_SEL_BIT];
  assign cmd        = shift_q[`DBG_CMD_LEN-1:0];

  // Modules only see strobes while the debug IR is active
  assign scan_capture = debug_select_i & capture_dr_i;
  assign scan_shift   = debug_select_i & shift_dr_i;
  // Select scans never reach the modules as commands
  assign cmd_update   = debug_select_i & update_dr_i & ~select_cmd;

  ////////////////////////////////////////
  // Module select
  ////////////////////////////////////////

  // Busy module blocks a new select
  assign select_inhibit = bus_inhibit | cpu_inhibit;

  // Blocked select is dropped, not deferred
  always_ff @(posedge tck_i or posedge tlr_i) begin
    if (tlr_i) begin
      module_q <= MOD_BUS;
    end else if (debug_select_i && update_dr_i && select_cmd && !select_inhibit) begin
      module_q <= dbg_module_e'(shift_q[`DBG_MODULE_ID_MSB -: `DBG_MODULE_ID_LEN]);
    end
  end

  // One-hot select lines
  always_comb begin
    module_sel           = '0;
    module_sel[module_q] = 1'b1;
  end

  ////////////////////////////////////////
  // TDO mux
  ////////////////////////////////////////

  // JSP and NONE slots stay low
  always_comb begin
    module_tdo          = '0;
    module_tdo[MOD_BUS] = bus_tdo;
    module_tdo[MOD_CPU] = cpu_tdo;
  end

  assign tdo_o = |(module_sel & module_tdo);

  ////////////////////////////////////////
  // Debug modules
  ////////////////////////////////////////

  dbg_bus_module i_bus (
    .tck_i          (tck_i),
    .tlr_i          (tlr_i),
    .capture_dr_i   (scan_capture),
    .shift_dr_i     (scan_shift),
    .update_dr_i    (cmd_update),
    .module_select_i(module_sel[MOD_BUS]),
    .cmd_i          (cmd),
    .module_tdo_o   (bus_tdo),
    .top_inhibit_o  (bus_inhibit),
    .bus_req_o      (bus_req_o),
    .bus_rsp_i      (bus_rsp_i)
  );

  dbg_cpu_module i_cpu (
    .tck_i          (tck_i),
    .tlr_i          (tlr_i),
    .capture_dr_i   (scan_capture),
    .shift_dr_i     (scan_shift),
    .update_dr_i    (cmd_update),
    .module_select_i(module_sel[MOD_CPU]),
    .cmd_i          (cmd),
    .module_tdo_o   (cpu_tdo),
    .top_inhibit_o  (cpu_inhibit),
    .cpu_req_o      (cpu_req_o),
    .cpu_rsp_i      (cpu_rsp_i),
    .cpu_bp_i       (cpu_bp_i),
    .cpu_stall_o    (cpu_stall_o)
  );

endmodule

`default_nettype wire

/* src/dbg_cpu_module.sv */
`default_nettype none

`include "dbg_settings.svh"

module dbg_cpu_module
  import dbg_cmd_pkg::*;
  import dbg_port_pkg::*;
(
  input  logic     tck_i,
  input  logic     tlr_i,
  input  logic     capture_dr_i,
  input  logic     shift_dr_i,
  input  logic     update_dr_i,
  input  logic     module_select_i,
  input  dbg_cmd_t cmd_i,
  output logic     module_tdo_o,
  output logic     top_inhibit_o,
  // CPU register port
  output cpu_req_t cpu_req_o,
  input  cpu_rsp_t cpu_rsp_i,
  // Breakpoint in, stall level out
  input  logic     cpu_bp_i,
  output logic     cpu_stall_o
);

  typedef enum logic {
    CPU_IDLE,
    CPU_WAIT
  } cpu_state_e;

  cpu_state_e                   state_q;
  cpu_op_e                      op;
  logic                         launch;
  logic                         stall_cmd;

  cpu_req_t                     req_q;
  logic [`DBG_DATA_WIDTH-1:0]   rdata_q;

  // Stall control
  logic                         bp_q;
  logic                         bp_rise;
  logic                         stall_q;

  logic [`DBG_READBACK_LEN-1:0] readback_q;

  ////////////////////////////////////////
  // Command decode
  ////////////////////////////////////////

  assign op = cpu_op_e'(cmd_i.opcode);

  always_comb begin
    launch    = 1'b0;
    stall_cmd = 1'b0;
    if (module_select_i && update_dr_i && (state_q == CPU_IDLE)) begin
      case (op)
        CPU_STALL:     stall_cmd = 1'b1;
        CPU_REG_WRITE,
        CPU_REG_READ:  launch = 1'b1;
        default:       launch = 1'b0;
      endcase
    end
  end

  ////////////////////////////////////////
  // Stall register
  ////////////////////////////////////////

  assign bp_rise = cpu_bp_i & ~bp_q;

  // Breakpoint edge wins over a clear in the same cycle
  always_ff @(posedge tck_i or posedge tlr_i) begin
    if (tlr_i) begin
      bp_q    <= 1'b0;
      stall_q <= 1'b0;
    end else begin
      bp_q <= cpu_bp_i;
      if (bp_rise) begin
        stall_q <= 1'b1;
      end else if (stall_cmd) begin
        stall_q <= cmd_i.data[0];
      end
    end
  end

  assign cpu_stall_o = stall_q;

  ////////////////////////////////////////
  // Register access FSM
  ////////////////////////////////////////

  always_ff @(posedge tck_i or posedge tlr_i) begin
    if (tlr_i) begin
      state_q <= CPU_IDLE;
      req_q   <= '0;
      rdata_q <= '0;
    end else if (state_q == CPU_IDLE) begin
      if (launch) begin
        state_q     <= CPU_WAIT;
        req_q.stb   <= 1'b1;
        req_q.we    <= (op == CPU_REG_WRITE);
        // Register number from low address bits
        req_q.addr  <= cmd_i.addr[`DBG_CPU_REG_ADDR_LEN-1:0];
        req_q.wdata <= cmd_i.data;
      end
    end else if (cpu_rsp_i.ack) begin
      state_q   <= CPU_IDLE;
      req_q.stb <= 1'b0;
      if (!req_q.we) begin
        rdata_q <= cpu_rsp_i.rdata;
      end
    end
  end

  assign cpu_req_o     = req_q;
  assign top_inhibit_o = (state_q == CPU_WAIT);

  ////////////////////////////////////////
  // Readback
  ////////////////////////////////////////

  // Stall status over last register read
  always_ff @(posedge tck_i or posedge tlr_i) begin
    if (tlr_i) begin
      readback_q <= '0;
    end else if (module_select_i && capture_dr_i) begin
      readback_q <= {stall_q, rdata_q};
    end else if (module_select_i && shift_dr_i) begin
      readback_q <= {1'b0, readback_q[`DBG_READBACK_LEN-1:1]};
    end
  end

  assign module_tdo_o = readback_q[0];

endmodule

`default_nettype wire

/* src/dbg_bus_module.sv */
`default_nettype none

`include "dbg_settings.svh"

module dbg_bus_module
  import dbg_cmd_pkg::*;
  import dbg_port_pkg::*;
(
  input  logic     tck_i,
  input  logic     tlr_i,
  // Strobes already qualified by the top
  input  logic     capture_dr_i,
  input  logic     shift_dr_i,
  input  logic     update_dr_i,
  input  logic     module_select_i,
  input  dbg_cmd_t cmd_i,
  output logic     module_tdo_o,
  output logic     top_inhibit_o,
  // Memory bus
  output bus_req_t bus_req_o,
  input  bus_rsp_t bus_rsp_i
);

  typedef enum logic {
    BUS_IDLE,
    BUS_WAIT
  } bus_state_e;

  bus_state_e                   state_q;
  bus_op_e                      op;
  logic                         launch;

  // Request held until ack
  bus_req_t                     req_q;

  // Result of the last access
  logic                         err_q;
  logic [`DBG_DATA_WIDTH-1:0]   rdata_q;

  // Readback chain
  logic [`DBG_READBACK_LEN-1:0] readback_q;

  ////////////////////////////////////////
  // Command decode
  ////////////////////////////////////////

  // Unknown codes fall to default
  assign op = bus_op_e'(cmd_i.opcode);

  // Updates while waiting are ignored
  always_comb begin
    launch = 1'b0;
    if (module_select_i && update_dr_i && (state_q == BUS_IDLE)) begin
      case (op)
        BUS_READ,
        BUS_WRITE: launch = 1'b1;
        // NOP and anything unknown
        default:   launch = 1'b0;
      endcase
    end
  end

  ////////////////////////////////////////
  // Access FSM
  ////////////////////////////////////////

  always_ff @(posedge tck_i or posedge tlr_i) begin
    if (tlr_i) begin
      state_q <= BUS_IDLE;
      req_q   <= '0;
      err_q   <= 1'b0;
      rdata_q <= '0;
    end else begin
      case (state_q)
        BUS_IDLE: begin
          // stb rises on the edge after update
          if (launch) begin
            state_q     <= BUS_WAIT;
            req_q.stb   <= 1'b1;
            req_q.we    <= (op == BUS_WRITE);
            req_q.addr  <= cmd_i.addr;
            req_q.wdata <= cmd_i.data;
          end
        end
        BUS_WAIT: begin
          // Single-cycle ack closes the access
          if (bus_rsp_i.ack) begin
            state_q   <= BUS_IDLE;
            req_q.stb <= 1'b0;
            err_q     <= bus_rsp_i.err;
            // Writes keep the previous read data
            if (!req_q.we) begin
              rdata_q <= bus_rsp_i.rdata;
            end
          end
        end
        default: begin
          state_q   <= BUS_IDLE;
          req_q.stb <= 1'b0;
        end
      endcase
    end
  end

  assign bus_req_o     = req_q;
  // Holds off module reselect
  assign top_inhibit_o = (state_q == BUS_WAIT);

  ////////////////////////////////////////
  // Readback
  ////////////////////////////////////////

  // Error flag on top of the last read word
  always_ff @(posedge tck_i or posedge tlr_i) begin
    if (tlr_i) begin
      readback_q <= '0;
    end else if (module_select_i && capture_dr_i) begin
      readback_q <= {err_q, rdata_q};
    end else if (module_select_i && shift_dr_i) begin
      // Zero fill once the word is out
      readback_q <= {1'b0, readback_q[`DBG_READBACK_LEN-1:1]};
    end
  end

  assign module_tdo_o = readback_q[0];

endmodule

`default_nettype wire

/* src/dbg_port_pkg.sv */
`default_nettype none

`include "dbg_settings.svh"

package dbg_port_pkg;

  ////////////////////////////////////////
  // Memory bus port
  ////////////////////////////////////////

  // Held stable while stb is high
  typedef struct packed {
    logic                       stb;
    logic                       we;
    logic [`DBG_ADDR_WIDTH-1:0] addr;
    logic [`DBG_DATA_WIDTH-1:0] wdata;
  } bus_req_t;

  // One-cycle ack, err and rdata valid with it
  typedef struct packed {
    logic                       ack;
    logic                       err;
    logic [`DBG_DATA_WIDTH-1:0] rdata;
  } bus_rsp_t;

  ////////////////////////////////////////
  // CPU register port
  ////////////////////////////////////////

  // Register number from low address bits
  typedef struct packed {
    logic                             stb;
    logic                             we;
    logic [`DBG_CPU_REG_ADDR_LEN-1:0] addr;
    logic [`DBG_DATA_WIDTH-1:0]       wdata;
  } cpu_req_t;

  typedef struct packed {
    logic                       ack;
    logic [`DBG_DATA_WIDTH-1:0] rdata;
  } cpu_rsp_t;

endpackage

`default_nettype wire

/* src/dbg_cmd_pkg.sv */
`default_nettype none

`include "dbg_settings.svh"

package dbg_cmd_pkg;

  ////////////////////////////////////////
  // Module numbers
  ////////////////////////////////////////

  // Serial port slot kept reserved, reads as zero
  typedef enum logic [`DBG_MODULE_ID_LEN-1:0] {
    MOD_BUS  = `DBG_MOD_BUS,
    MOD_CPU  = `DBG_MOD_CPU,
    MOD_JSP  = `DBG_MOD_JSP,
    MOD_NONE = `DBG_MOD_NONE
  } dbg_module_e;

  ////////////////////////////////////////
  // Opcodes
  ////////////////////////////////////////

  // Bus module, single 32-bit accesses
  typedef enum logic [`DBG_OPCODE_LEN-1:0] {
    BUS_NOP   = 0,
    BUS_WRITE = 1,
    BUS_READ  = 2
  } bus_op_e;

  // CPU module, data bit 0 carries the stall level
  typedef enum logic [`DBG_OPCODE_LEN-1:0] {
    CPU_NOP       = 0,
    CPU_STALL     = 1,
    CPU_REG_WRITE = 2,
    CPU_REG_READ  = 3
  } cpu_op_e;

  // Data register minus select bit
  // Opcode left raw, each module casts to its own enum
  typedef struct packed {
    logic [`DBG_OPCODE_LEN-1:0] opcode;
    logic [`DBG_ADDR_WIDTH-1:0] addr;
    logic [`DBG_DATA_WIDTH-1:0] data;
  } dbg_cmd_t;

endpackage

`default_nettype wire

/* include/dbg_settings.svh */
`ifndef DBG_SETTINGS_SVH
`define DBG_SETTINGS_SVH

////////////////////////////////////////
// Main data register
////////////////////////////////////////

// Full scan length, select bit on top
`define DBG_DATAREG_LEN 69
`define DBG_SEL_BIT 68

// Command part below the select bit
`define DBG_CMD_LEN 68

// Module number just below the select bit
`define DBG_MODULE_ID_LEN 2
`define DBG_MODULE_ID_MSB 67

// Command fields
`define DBG_OPCODE_LEN 4
`define DBG_ADDR_WIDTH 32
`define DBG_DATA_WIDTH 32
`define DBG_CPU_REG_ADDR_LEN 16

// Readback, status bit above the data word
`define DBG_READBACK_LEN 33

// Module numbers
`define DBG_MOD_BUS 0
`define DBG_MOD_CPU 1
`define DBG_MOD_JSP 2
`define DBG_MOD_NONE 3

`endif
